// File: common/memif_pkg.sv
package memif_pkg;

    ///////////////////////////////////////////////////////////////////////
    // widths and depths
    ///////////////////////////////////////////////////////////////////////

    // cpu word address, byte bits already stripped
    localparam int addr_w       = 30;
    localparam int main_words   = 256;
    localparam int loader_words = 64;
    localparam int text_bytes   = 1024;
    localparam int trace_depth  = 16;

    // index widths derived from the depths
    localparam int main_aw   = $clog2(main_words);
    localparam int loader_aw = $clog2(loader_words);
    localparam int text_aw   = $clog2(text_bytes);

    ///////////////////////////////////////////////////////////////////////
    // region map, top nibble of the word address
    ///////////////////////////////////////////////////////////////////////

    localparam logic [3:0] rgn_text   = 4'hc;
    localparam logic [3:0] rgn_dbg    = 4'hd;
    localparam logic [3:0] rgn_kbd    = 4'he;
    localparam logic [3:0] rgn_loader = 4'hf;

    // trap window tag sits in offset bits 25..18
    localparam logic [7:0] trap_tag = 8'hdd;

    // debug word offsets of the two queue pointers
    localparam logic [addr_w-5:0] dbg_start_ofs = 26'd1;
    localparam logic [addr_w-5:0] dbg_end_ofs   = 26'd2;

    ///////////////////////////////////////////////////////////////////////
    // timing and queue constants
    ///////////////////////////////////////////////////////////////////////

    localparam int main_lat    = 4;
    localparam int main_cnt_w  = 3;
    localparam int text_spin   = 3;
    localparam int trace_ptr_w = 4;

    // data port request, held by the cpu while stalled
    typedef struct packed {
        logic              read;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        be;
    } dmem_req_t;

    // one byte toward the text store
    typedef struct packed {
        logic               wen;
        logic [text_aw-1:0] addr;
        logic [7:0]         char_data;
    } text_wr_t;

    // word 1 in the upper half, word 0 in the lower half
    typedef struct packed {
        logic [10:0]           pad;
        logic                  wr_flag;
        logic                  rd_flag;
        logic [main_cnt_w-1:0] count;
        logic [15:0]           wdata_lo;
        logic [31:0]           req_addr;
    } trace_entry_t;

endpackage

// File: src/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder import memif_pkg::*; (
    input  dmem_req_t         dmem,
    input  logic [addr_w-1:0] instr_addr,
    input  logic [31:0]       main_rdata,
    input  logic [31:0]       loader_data,
    input  logic [31:0]       loader_instr,
    input  logic [31:0]       trace_word,
    input  logic [trace_ptr_w-1:0] trace_start,
    input  logic [trace_ptr_w-1:0] trace_end,
    output logic              main_rd,
    output logic              main_wr,
    output logic              loader_en,
    output logic              loader_wen,
    output logic              text_sel,
    output text_wr_t          text_wr,
    output logic              trap_stall,
    output logic [31:0]       dmem_data_out,
    output logic [31:0]       instr_data_out
);

    logic [3:0]        rgn;
    logic [addr_w-5:0] ofs;
    logic [1:0]        lane;
    logic [7:0]        lane_char;

    // region code and offset inside the region
    assign rgn = dmem.addr[addr_w-1 -: 4];
    assign ofs = dmem.addr[addr_w-5:0];

    ///////////////////////////////////////////////////////////////////////
    // data port steering
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        // idle defaults, nothing touched
        main_rd       = 1'b0;
        main_wr       = 1'b0;
        loader_en     = 1'b0;
        loader_wen    = 1'b0;
        text_sel      = 1'b0;
        trap_stall    = 1'b0;
        dmem_data_out = '0;

        if (rgn == rgn_text) begin
            // write only, reads come back as zero
            text_sel = 1'b1;
        end else if (rgn == rgn_loader) begin
            loader_en     = 1'b1;
            loader_wen    = dmem.write;
            dmem_data_out = loader_data;
        end else if (rgn == rgn_dbg) begin
            if (ofs[addr_w-5 -: 8] == trap_tag) begin
                // hold the pipe for as long as the access lasts
                trap_stall = dmem.read | dmem.write;
            end else if (ofs == dbg_start_ofs) begin
                dmem_data_out = {{(32-trace_ptr_w){1'b0}}, trace_start};
            end else if (ofs == dbg_end_ofs) begin
                dmem_data_out = {{(32-trace_ptr_w){1'b0}}, trace_end};
            end else begin
                // entry and half picked at the top level from bits 5..1
                dmem_data_out = trace_word;
            end
        end else if (rgn == rgn_kbd) begin
            // no keyboard behind this region
            dmem_data_out = '0;
        end else begin
            // everything else is main memory
            main_rd       = dmem.read;
            main_wr       = dmem.write;
            dmem_data_out = main_rdata;
        end
    end

    // fetch path, loader only
    assign instr_data_out = (instr_addr[addr_w-1 -: 4] == rgn_loader) ? loader_instr : '0;

    // byte lane for text writes, be[3] is the lowest byte address
    always_comb begin
        case (dmem.be)
            4'b1000: begin
                lane      = 2'd0;
                lane_char = dmem.wdata[7:0];
            end
            4'b0100: begin
                lane      = 2'd1;
                lane_char = dmem.wdata[15:8];
            end
            4'b0010: begin
                lane      = 2'd2;
                lane_char = dmem.wdata[23:16];
            end
            default: begin
                // 4'b0001, and any bad enable lands here too
                lane      = 2'd3;
                lane_char = dmem.wdata[31:24];
            end
        endcase
    end

    assign text_wr.wen       = dmem.write;
    assign text_wr.addr      = {dmem.addr[text_aw-3:0], lane};
    assign text_wr.char_data = lane_char;

endmodule

// File: src/text_port.sv
`timescale 1ns/1ps

module text_port import memif_pkg::*; (
    input  logic               clk_for_ddr,
    input  logic               rst,
    input  logic               text_sel,
    input  text_wr_t           text_wr,
    input  logic [text_aw-1:0] text_rd_addr,
    output logic               text_stall,
    output logic [7:0]         text_rd_char
);

    logic       req;
    logic [1:0] spin;
    logic       wen;
    logic [7:0] mem [text_bytes];

    // write request into the text region
    assign req = text_sel & text_wr.wen;

    // stalls at once, released when the spin count is terminal
    assign text_stall = req && (spin < 2'(text_spin));

    ///////////////////////////////////////////////////////////////////////
    // stall sequencer
    ///////////////////////////////////////////////////////////////////////

    // count meaning
    //   0 idle
    //   1 first write cycle
    //   2 second write cycle
    //   3 done, spins here until the cpu drops the request
    always_ff @(posedge clk_for_ddr) begin
        if (!rst) begin
            spin <= 2'd0;
            wen  <= 1'b0;
        end else if (!req) begin
            // request gone, back to idle
            spin <= 2'd0;
            wen  <= 1'b0;
        end else if (spin >= 2'(text_spin - 1)) begin
            // last write edge, enable drops
            spin <= 2'(text_spin);
            wen  <= 1'b0;
        end else begin
            spin <= spin + 2'd1;
            wen  <= 1'b1;
        end
    end

    // byte lands on both enable edges, same address and char
    always_ff @(posedge clk_for_ddr) begin
        if (wen) begin
            mem[text_wr.addr] <= text_wr.char_data;
        end
    end

    // display side, plain async read
    assign text_rd_char = mem[text_rd_addr];

endmodule

// File: src/loader_mem.sv
`timescale 1ns/1ps

module loader_mem import memif_pkg::*; (
    input  logic                 clk_for_ddr,
    input  logic [loader_aw-1:0] data_addr,
    input  logic [31:0]          wdata,
    input  logic                 wen,
    input  logic [loader_aw-1:0] instr_addr,
    output logic [31:0]          data_rdata,
    output logic [31:0]          instr_rdata
);

    // distributed ram, two read ports
    logic [31:0] mem [loader_words];

    // data port write
    always_ff @(posedge clk_for_ddr) begin
        if (wen) begin
            mem[data_addr] <= wdata;
        end
    end

    // data port read, same cycle
    assign data_rdata = mem[data_addr];

    // fetch port, read only
    assign instr_rdata = mem[instr_addr];

endmodule

// File: src/main_mem_port.sv
`timescale 1ns/1ps

module main_mem_port import memif_pkg::*; (
    input  logic                  clk_for_ddr,
    input  logic                  rst,
    input  logic                  main_rd,
    input  logic                  main_wr,
    input  dmem_req_t             dmem,
    output logic                  main_stall,
    output logic [main_cnt_w-1:0] main_count,
    output logic [31:0]           main_rdata
);

    logic                 req;
    logic                 done;
    logic [main_aw-1:0]   idx;
    logic [31:0]          mem [main_words];

    assign req = main_rd | main_wr;
    assign idx = dmem.addr[main_aw-1:0];

    // stall from the first request cycle, main_lat cycles in all
    assign main_stall = req && (main_count < main_cnt_w'(main_lat));

    // last stall cycle, commit on its edge
    assign done = req && (main_count == main_cnt_w'(main_lat - 1));

    ///////////////////////////////////////////////////////////////////////
    // latency counter
    ///////////////////////////////////////////////////////////////////////

    // counts up while stalled, parks at main_lat
    // so a held request is not served twice
    always_ff @(posedge clk_for_ddr) begin
        if (!rst) begin
            main_count <= '0;
        end else if (!req) begin
            main_count <= '0;
        end else if (main_stall) begin
            main_count <= main_count + 1'b1;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // word store
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_for_ddr) begin
        if (done && main_wr) begin
            // merge by byte enable
            for (int i = 0; i < 4; i++) begin
                if (dmem.be[i]) begin
                    mem[idx][8*i +: 8] <= dmem.wdata[8*i +: 8];
                end
            end
        end
    end

    // read word held for the cpu once the stall is over
    always_ff @(posedge clk_for_ddr) begin
        if (done && main_rd) begin
            main_rdata <= mem[idx];
        end
    end

endmodule

// File: src/trace_queue.sv
`timescale 1ns/1ps

module trace_queue import memif_pkg::*; (
    input  logic                   clk_for_ddr,
    input  logic                   rst,
    input  logic                   main_stall,
    input  logic [main_cnt_w-1:0]  main_count,
    input  dmem_req_t              dmem,
    input  logic [trace_ptr_w-1:0] rd_index,
    input  logic                   rd_half,
    output logic [31:0]            trace_word,
    output logic [trace_ptr_w-1:0] trace_start,
    output logic [trace_ptr_w-1:0] trace_end
);

    trace_entry_t ring [trace_depth];
    trace_entry_t entry;
    trace_entry_t rd_entry;
    logic         run;

    // snapshot of the stalled request
    always_comb begin
        entry          = '0;
        entry.req_addr = {{(32-addr_w){1'b0}}, dmem.addr};
        entry.wdata_lo = dmem.wdata[15:0];
        entry.count    = main_count;
        entry.rd_flag  = dmem.read;
        entry.wr_flag  = dmem.write;
    end

    ///////////////////////////////////////////////////////////////////////
    // pointers and run flag
    ///////////////////////////////////////////////////////////////////////

    // run is set for the length of one stall burst
    always_ff @(posedge clk_for_ddr) begin
        if (!rst) begin
            run         <= 1'b0;
            trace_start <= '0;
            trace_end   <= '0;
        end else if (!main_stall) begin
            run <= 1'b0;
        end else begin
            if (!run) begin
                // new burst starts where the last one ended
                run         <= 1'b1;
                trace_start <= trace_end;
            end
            // wraps, oldest entries get overwritten
            trace_end <= trace_end + 1'b1;
        end
    end

    // one entry per stalled cycle
    always_ff @(posedge clk_for_ddr) begin
        if (main_stall) begin
            ring[trace_end] <= entry;
        end
    end

    // readback, half 1 is the flags word
    assign rd_entry   = ring[rd_index];
    assign trace_word = rd_half ? rd_entry[63:32] : rd_entry[31:0];

endmodule

// File: src/cpu_interface.sv
`timescale 1ns/1ps

module cpu_interface import memif_pkg::*; (
    input  logic               clk_for_ddr,
    input  logic               rst,
    input  dmem_req_t          dmem,
    input  logic [addr_w-1:0]  instr_addr,
    input  logic [text_aw-1:0] text_rd_addr,
    output logic [31:0]        dmem_data_out,
    output logic [31:0]        instr_data_out,
    output logic               mem_stall,
    output logic [7:0]         text_rd_char
);

    logic                   main_rd;
    logic                   main_wr;
    logic                   loader_en;
    logic                   loader_wen;
    logic                   loader_we;
    logic                   text_sel;
    logic                   trap_stall;
    text_wr_t               text_wr;
    logic                   main_stall;
    logic [main_cnt_w-1:0]  main_count;
    logic [31:0]            main_rdata;
    logic                   text_stall;
    logic [31:0]            loader_data;
    logic [31:0]            loader_instr;
    logic [31:0]            trace_word;
    logic [trace_ptr_w-1:0] trace_start;
    logic [trace_ptr_w-1:0] trace_end;

    // any source holds the pipe
    assign mem_stall = main_stall | text_stall | trap_stall;

    // loader write only on an edge the pipe moves
    assign loader_we = loader_en & loader_wen & ~mem_stall;

    addr_decoder i_addr_decoder (
        .dmem           (dmem),
        .instr_addr     (instr_addr),
        .main_rdata     (main_rdata),
        .loader_data    (loader_data),
        .loader_instr   (loader_instr),
        .trace_word     (trace_word),
        .trace_start    (trace_start),
        .trace_end      (trace_end),
        .main_rd        (main_rd),
        .main_wr        (main_wr),
        .loader_en      (loader_en),
        .loader_wen     (loader_wen),
        .text_sel       (text_sel),
        .text_wr        (text_wr),
        .trap_stall     (trap_stall),
        .dmem_data_out  (dmem_data_out),
        .instr_data_out (instr_data_out)
    );

    text_port i_text_port (
        .clk_for_ddr  (clk_for_ddr),
        .rst          (rst),
        .text_sel     (text_sel),
        .text_wr      (text_wr),
        .text_rd_addr (text_rd_addr),
        .text_stall   (text_stall),
        .text_rd_char (text_rd_char)
    );

    // low word bits index the loader on both ports
    loader_mem i_loader_mem (
        .clk_for_ddr (clk_for_ddr),
        .data_addr   (dmem.addr[loader_aw-1:0]),
        .wdata       (dmem.wdata),
        .wen         (loader_we),
        .instr_addr  (instr_addr[loader_aw-1:0]),
        .data_rdata  (loader_data),
        .instr_rdata (loader_instr)
    );

    main_mem_port i_main_mem_port (
        .clk_for_ddr (clk_for_ddr),
        .rst         (rst),
        .main_rd     (main_rd),
        .main_wr     (main_wr),
        .dmem        (dmem),
        .main_stall  (main_stall),
        .main_count  (main_count),
        .main_rdata  (main_rdata)
    );

    // entry from bits 5..2, half from bit 1
    trace_queue i_trace_queue (
        .clk_for_ddr (clk_for_ddr),
        .rst         (rst),
        .main_stall  (main_stall),
        .main_count  (main_count),
        .dmem        (dmem),
        .rd_index    (dmem.addr[5:2]),
        .rd_half     (dmem.addr[1]),
        .trace_word  (trace_word),
        .trace_start (trace_start),
        .trace_end   (trace_end)
    );

endmodule

// File: tests/cpu_interface_props.sv
`timescale 1ns/1ps

module cpu_interface_props import memif_pkg::*; (
    input logic      clk_for_ddr,
    input logic      rst,
    input logic      mem_stall,
    input logic      main_stall,
    input dmem_req_t dmem,
    input logic      text_wen
);

    // read back by the testbench at the end of the run
    int unsigned fail_count = 0;
    logic [2:0]  main_run;
    logic [2:0]  wen_run;

    ///////////////////////////////////////////////////////////////////////
    // run length counters
    ///////////////////////////////////////////////////////////////////////

    // cycles of the current run so far, zero when idle
    always_ff @(posedge clk_for_ddr) begin
        if (!rst) begin
            main_run <= '0;
            wen_run  <= '0;
        end else begin
            main_run <= main_stall ? main_run + 3'd1 : 3'd0;
            wen_run  <= text_wen ? wen_run + 3'd1 : 3'd0;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // properties
    ///////////////////////////////////////////////////////////////////////

    // pipe free straight out of reset
    a_reset_idle: assert property (@(posedge clk_for_ddr) !rst |=> !mem_stall)
        else begin
            $error("mem_stall high in the cycle after reset");
            fail_count++;
        end

    // never more than main_lat cycles
    a_main_max: assert property (@(posedge clk_for_ddr) disable iff (!rst)
        main_stall |-> main_run < 3'(main_lat))
        else begin
            $error("main_stall longer than main_lat cycles");
            fail_count++;
        end

    // a finished run was exactly main_lat long
    a_main_full: assert property (@(posedge clk_for_ddr) disable iff (!rst)
        (!main_stall && main_run != 3'd0) |-> main_run == 3'(main_lat))
        else begin
            $error("main_stall shorter than main_lat cycles");
            fail_count++;
        end

    // two enable cycles per byte at most
    a_text_wen: assert property (@(posedge clk_for_ddr) disable iff (!rst)
        text_wen |-> wen_run < 3'd2)
        else begin
            $error("text write enable high for more than two cycles");
            fail_count++;
        end

    // access into the trap window holds the pipe
    a_trap_stall: assert property (@(posedge clk_for_ddr) disable iff (!rst)
        (dmem.addr[addr_w-1 -: 4] == rgn_dbg && dmem.addr[addr_w-5 -: 8] == trap_tag
         && (dmem.read || dmem.write)) |-> mem_stall)
        else begin
            $error("trap window access without mem_stall");
            fail_count++;
        end

endmodule

// props ride along inside every cpu_interface
bind cpu_interface cpu_interface_props i_cpu_interface_props (
    .clk_for_ddr (clk_for_ddr),
    .rst         (rst),
    .mem_stall   (mem_stall),
    .main_stall  (main_stall),
    .dmem        (dmem),
    .text_wen    (i_text_port.wen)
);

// File: tests/tb_cpu_interface.sv
`timescale 1ns/1ps

module tb_cpu_interface import memif_pkg::*; ();

    logic               clk_for_ddr;
    logic               rst;
    dmem_req_t          dmem;
    logic [addr_w-1:0]  instr_addr;
    logic [text_aw-1:0] text_rd_addr;
    logic [31:0]        dmem_data_out;
    logic [31:0]        instr_data_out;
    logic               mem_stall;
    logic [7:0]         text_rd_char;

    int          seed = 57464;
    int          errors;
    int          tests;
    int          passed;
    // outputs captured in the first cycle without a stall
    int          last_stalls;
    logic [31:0] last_rdata;
    logic [31:0] last_fetch;
    logic [7:0]  last_char;

    cpu_interface i_cpu_interface (
        .clk_for_ddr    (clk_for_ddr),
        .rst            (rst),
        .dmem           (dmem),
        .instr_addr     (instr_addr),
        .text_rd_addr   (text_rd_addr),
        .dmem_data_out  (dmem_data_out),
        .instr_data_out (instr_data_out),
        .mem_stall      (mem_stall),
        .text_rd_char   (text_rd_char)
    );

    // 20 ns period
    initial begin
        clk_for_ddr = 1'b0;
        forever #10 clk_for_ddr = ~clk_for_ddr;
    end

    ///////////////////////////////////////////////////////////////////////
    // reference rules
    ///////////////////////////////////////////////////////////////////////

    // word after a write, only enabled bytes change
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // text byte offset, be[3] is offset 0, bad enables act as be[0]
    function automatic logic [1:0] lane_of(input logic [3:0] be);
        case (be)
            4'b1000: return 2'd0;
            4'b0100: return 2'd1;
            4'b0010: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    // offset n carries data byte n
    function automatic logic [7:0] lane_byte(input logic [31:0] data, input logic [3:0] be);
        return data[8*lane_of(be) +: 8];
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // bus helpers
    ///////////////////////////////////////////////////////////////////////

    // one request held until mem_stall falls, then dropped
    task automatic access(input logic rd, input logic wr, input logic [addr_w-1:0] addr,
                          input logic [31:0] wdata, input logic [3:0] be);
        dmem_req_t req;
        req.read  = rd;
        req.write = wr;
        req.addr  = addr;
        req.wdata = wdata;
        req.be    = be;
        @(posedge clk_for_ddr);
        dmem <= req;
        last_stalls = 0;
        @(negedge clk_for_ddr);
        // bounded wait, 20 cycles is far past any legal stall
        while (mem_stall && last_stalls < 20) begin
            last_stalls++;
            @(negedge clk_for_ddr);
        end
        if (mem_stall) begin
            $display("timeout at %0t: mem_stall stuck high for address %h", $time, addr);
            errors++;
        end
        last_rdata = dmem_data_out;
        last_fetch = instr_data_out;
        last_char  = text_rd_char;
        @(posedge clk_for_ddr);
        dmem <= '0;
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            passed++;
            $display("test %-8s ok", name);
        end else begin
            $display("test %-8s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // test sequence
    ///////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]            model [8];
        logic [31:0]            data;
        logic [3:0]             be;
        logic [7:0]             idx;
        logic [addr_w-1:0]      addr;
        logic [trace_ptr_w-1:0] old_end;
        logic [trace_ptr_w-1:0] new_end;
        logic [trace_ptr_w-1:0] slot;
        int                     mark;

        rst          = 1'b0;
        dmem         = '0;
        instr_addr   = '0;
        text_rd_addr = '0;
        errors       = 0;
        tests        = 0;
        passed       = 0;
        repeat (3) @(posedge clk_for_ddr);
        rst <= 1'b1;
        repeat (2) @(posedge clk_for_ddr);

        // main memory, full words first so no byte stays unknown
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            idx  = 8'(i * 37 + 5);
            data = $random(seed);
            access(1'b0, 1'b1, {4'h1, 18'(i), idx}, data, 4'hf);
            model[i] = data;
            check("main write stall", 32'(last_stalls), 32'd4);
        end
        for (int i = 0; i < 8; i++) begin
            idx  = 8'(i * 37 + 5);
            data = $random(seed);
            be   = 4'($random(seed));
            access(1'b0, 1'b1, {4'h1, 18'(i), idx}, data, be);
            model[i] = merge_bytes(model[i], data, be);
        end
        for (int i = 0; i < 8; i++) begin
            idx = 8'(i * 37 + 5);
            access(1'b1, 1'b0, {4'h1, 18'(i), idx}, 32'd0, 4'h0);
            check("main read", last_rdata, model[i]);
            check("main read stall", 32'(last_stalls), 32'd4);
        end
        report_test("main", mark);

        // text, every one-hot lane twice
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            be   = 4'b1000 >> (i % 4);
            data = $random(seed);
            addr = {4'hc, 18'($random(seed)), 8'(i * 19 + 3)};
            text_rd_addr <= {addr[text_aw-3:0], lane_of(be)};
            access(1'b0, 1'b1, addr, data, be);
            check("text char", 32'(last_char), 32'(lane_byte(data, be)));
            check("text stall", 32'(last_stalls), 32'd3);
        end
        report_test("text", mark);

        // loader, written by data port, read by both ports
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            data = $random(seed);
            model[i] = data;
            access(1'b0, 1'b1, {4'hf, 20'(i), 6'(i * 7 + 1)}, data, 4'hf);
            check("loader write stall", 32'(last_stalls), 32'd0);
        end
        for (int i = 0; i < 8; i++) begin
            instr_addr <= {4'hf, 20'd0, 6'(i * 7 + 1)};
            access(1'b1, 1'b0, {4'hf, 20'(i), 6'(i * 7 + 1)}, 32'd0, 4'h0);
            check("loader data read", last_rdata, model[i]);
            check("loader fetch", last_fetch, model[i]);
        end
        report_test("loader", mark);

        // trap window, stall follows the held request
        mark = errors;
        addr = {4'hd, trap_tag, 18'($random(seed))};
        @(posedge clk_for_ddr);
        dmem.read <= 1'b1;
        dmem.addr <= addr;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk_for_ddr);
            check("trap stall held", 32'(mem_stall), 32'd1);
        end
        @(posedge clk_for_ddr);
        dmem <= '0;
        @(negedge clk_for_ddr);
        check("trap stall released", 32'(mem_stall), 32'd0);
        report_test("trap", mark);

        // trace, one main read adds main_lat entries
        mark = errors;
        access(1'b1, 1'b0, {4'hd, dbg_end_ofs}, 32'd0, 4'h0);
        old_end = last_rdata[trace_ptr_w-1:0];
        new_end = old_end + 4'd4;
        addr = {4'h1, 18'd3, 8'(3 * 37 + 5)};
        access(1'b1, 1'b0, addr, 32'd0, 4'h0);
        access(1'b1, 1'b0, {4'hd, dbg_start_ofs}, 32'd0, 4'h0);
        check("trace start", last_rdata, 32'(old_end));
        access(1'b1, 1'b0, {4'hd, dbg_end_ofs}, 32'd0, 4'h0);
        check("trace end", last_rdata, 32'(new_end));
        for (int i = 0; i < 4; i++) begin
            slot = old_end + 4'(i);
            // entry in bits 5..2, half 0
            access(1'b1, 1'b0, {4'hd, 20'd0, slot, 2'b00}, 32'd0, 4'h0);
            check("trace entry address", last_rdata, {2'b00, addr});
        end
        report_test("trace", mark);

        // keyboard region and fetches outside the loader read zero
        mark = errors;
        for (int i = 0; i < 4; i++) begin
            instr_addr <= {4'(i * 4 + 1), 26'($random(seed))};
            access(1'b1, 1'b0, {4'he, 26'($random(seed))}, 32'd0, 4'h0);
            check("keyboard read", last_rdata, 32'd0);
            check("fetch outside loader", last_fetch, 32'd0);
        end
        report_test("default", mark);

        // bound property failures count too
        errors += int'(i_cpu_interface.i_cpu_interface_props.fail_count);
        $display("tests %0d, passed %0d, errors %0d", tests, passed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: cpu_interface.f
common/memif_pkg.sv
src/addr_decoder.sv
src/text_port.sv
src/loader_mem.sv
src/main_mem_port.sv
src/trace_queue.sv
src/cpu_interface.sv
tests/cpu_interface_props.sv
tests/tb_cpu_interface.sv

// File: Makefile
TOP = tb_cpu_interface

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f cpu_interface.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cpu_interface.f
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
